// File: verilog/hps_io_params.svh
//////////////////////////////////////////////////
// host command port constants
// widths, counts and the special key sequences
//////////////////////////////////////////////////
`ifndef HPS_IO_PARAMS_SVH
`define HPS_IO_PARAMS_SVH

// saturating word counter within a frame
`define HPS_IO_WORD_CNT_W 6

`define HPS_IO_NUM_JOY 6
`define HPS_IO_STATUS_W 128
`define HPS_IO_ADDR_W 27

// raw keyboard sequences with no single scan code
`define HPS_IO_KEY_PRNSCR_DN 32'hE012E07C
`define HPS_IO_KEY_PRNSCR_UP 32'h7CE0F012
`define HPS_IO_KEY_PAUSE_DN 32'hF014F077

// codes reported in ps2_key[9:0] for them
`define HPS_IO_CODE_PRNSCR_DN 10'h37C
`define HPS_IO_CODE_PRNSCR_UP 10'h17C
`define HPS_IO_CODE_PAUSE_DN 10'h377

`endif

// File: verilog/hps_io_pkg.sv
//////////////////////////////////////////////////
// host command port types
// command encodings and bus word types
//////////////////////////////////////////////////
package hps_io_pkg;

	typedef logic [15:0] io_word_t;
	typedef logic [31:0] joy_word_t;

	// user port commands, framed by io_enable
	typedef enum logic [7:0] {
		NONE       = 8'h00,
		CFG        = 8'h01,
		JOY0       = 8'h02,
		JOY1       = 8'h03,
		MOUSE      = 8'h04,
		KBD        = 8'h05,
		JOY_RAW    = 8'h0F,
		JOY2       = 8'h10,
		JOY3       = 8'h11,
		JOY4       = 8'h12,
		JOY5       = 8'h13,
		STATUS     = 8'h1E,
		STATUS_REQ = 8'h29,
		MENUMASK   = 8'h2E,
		SDRAM_SZ   = 8'h31,
		INFO       = 8'h36
	} uio_cmd_e;

	// file channel commands, framed by fp_enable
	typedef enum logic [7:0] {
		FILE_TX     = 8'h53,
		FILE_TX_DAT = 8'h54,
		FILE_INDEX  = 8'h55,
		FILE_INFO   = 8'h56
	} fio_cmd_e;

	// unknown command words map to NONE
	function automatic uio_cmd_e uio_decode(input io_word_t w);
		uio_cmd_e c;
		c = uio_cmd_e'(w[7:0]);
		if (w[15:8] != 8'h00 || !(c inside {CFG, JOY0, JOY1, MOUSE, KBD, JOY_RAW, JOY2, JOY3,
				JOY4, JOY5, STATUS, STATUS_REQ, MENUMASK, SDRAM_SZ, INFO}))
			c = NONE;
		return c;
	endfunction

endpackage

// File: verilog/uio_frame.sv
//////////////////////////////////////////////////
// uio_frame
// command latch, word counter, frame end pulse
// and the registered reply word
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "hps_io_params.svh"

module uio_frame (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          io_enable,
	input  logic                          io_strobe,
	input  hps_io_pkg::io_word_t          io_din,
	output hps_io_pkg::uio_cmd_e          cmd,
	output logic [`HPS_IO_WORD_CNT_W-1:0] word_idx,
	output logic                          data_stb,
	output logic                          frame_end,
	input  hps_io_pkg::io_word_t          stflg_word,
	input  hps_io_pkg::io_word_t          info_word,
	input  logic [`HPS_IO_STATUS_W-1:0]   status_req,
	input  hps_io_pkg::io_word_t          joy_raw,
	input  hps_io_pkg::io_word_t          status_menumask,
	output hps_io_pkg::io_word_t          io_dout
);

	hps_io_pkg::uio_cmd_e cmd_in;
	hps_io_pkg::io_word_t reply;
	logic                 cmd_open;
	logic [2:0]           slice;

	assign cmd_open = (word_idx != '0);
	assign data_stb = io_enable & io_strobe & cmd_open;
	assign cmd_in   = hps_io_pkg::uio_decode(io_din);

	// status slice for word k is k-1
	assign slice = word_idx[2:0] - 3'd1;

	//////////////////////////////////////////////////
	// reply selection
	//////////////////////////////////////////////////
	always_comb begin
		reply = '0;
		if (!cmd_open) begin
			case (cmd_in)
				hps_io_pkg::STATUS_REQ: reply = stflg_word;
				hps_io_pkg::INFO:       reply = info_word;
				default:                reply = '0;
			endcase
		end else begin
			case (cmd)
				hps_io_pkg::STATUS_REQ: begin
					if (word_idx <= 8)
						reply = status_req[{slice, 4'b0000} +: 16];
				end
				hps_io_pkg::JOY_RAW: reply = joy_raw;
				hps_io_pkg::MENUMASK: begin
					if (word_idx == 1)
						reply = status_menumask;
				end
				default: reply = '0;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// frame tracking
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd       <= hps_io_pkg::NONE;
			word_idx  <= '0;
			frame_end <= 1'b0;
			io_dout   <= '0;
		end else begin
			// cmd stays valid through the frame_end cycle
			frame_end <= ~io_enable & cmd_open;
			if (!io_enable) begin
				word_idx <= '0;
				io_dout  <= '0;
			end else if (io_strobe) begin
				io_dout <= reply;
				if (!cmd_open)
					cmd <= cmd_in;
				if (~&word_idx)
					word_idx <= word_idx + 1'b1;
			end
		end
	end

endmodule

// File: verilog/uio_settings.sv
//////////////////////////////////////////////////
// uio_settings
// config, joystick, status and SDRAM size
// registers written by the host
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "hps_io_params.svh"

module uio_settings (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  hps_io_pkg::uio_cmd_e          cmd,
	input  logic [`HPS_IO_WORD_CNT_W-1:0] word_idx,
	input  logic                          data_stb,
	input  hps_io_pkg::io_word_t          io_din,
	output hps_io_pkg::joy_word_t         joystick_0,
	output hps_io_pkg::joy_word_t         joystick_1,
	output hps_io_pkg::joy_word_t         joystick_2,
	output hps_io_pkg::joy_word_t         joystick_3,
	output hps_io_pkg::joy_word_t         joystick_4,
	output hps_io_pkg::joy_word_t         joystick_5,
	output logic [1:0]                    buttons,
	output logic                          forced_scandoubler,
	output logic                          direct_video,
	output logic [`HPS_IO_STATUS_W-1:0]   status,
	output logic [15:0]                   sdram_sz
);

	hps_io_pkg::io_word_t  cfg;
	hps_io_pkg::joy_word_t joy [`HPS_IO_NUM_JOY];
	logic [2:0]            joy_sel;
	logic                  joy_hit;
	logic [2:0]            slice;

	assign slice = word_idx[2:0] - 3'd1;

	// joystick number from the command
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 3'd0;
		case (cmd)
			hps_io_pkg::JOY0: joy_sel = 3'd0;
			hps_io_pkg::JOY1: joy_sel = 3'd1;
			hps_io_pkg::JOY2: joy_sel = 3'd2;
			hps_io_pkg::JOY3: joy_sel = 3'd3;
			hps_io_pkg::JOY4: joy_sel = 3'd4;
			hps_io_pkg::JOY5: joy_sel = 3'd5;
			default:          joy_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cfg      <= '0;
			status   <= '0;
			sdram_sz <= '0;
			for (int i = 0; i < `HPS_IO_NUM_JOY; i++)
				joy[i] <= '0;
		end else if (data_stb) begin
			// word 1 is the low half, the rest the high half
			if (joy_hit) begin
				if (word_idx == 1)
					joy[joy_sel][15:0] <= io_din;
				else
					joy[joy_sel][31:16] <= io_din;
			end
			case (cmd)
				hps_io_pkg::CFG: cfg <= io_din;
				hps_io_pkg::STATUS: begin
					if (word_idx <= 8)
						status[{slice, 4'b0000} +: 16] <= io_din;
				end
				hps_io_pkg::SDRAM_SZ: begin
					if (word_idx == 1)
						sdram_sz <= io_din;
				end
				default: ;
			endcase
		end
	end

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];
	assign joystick_4 = joy[4];
	assign joystick_5 = joy[5];

	// config word fields
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

endmodule

// File: verilog/host_requests.sv
//////////////////////////////////////////////////
// host_requests
// core-side status and info requests held for
// the host to read back
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "hps_io_params.svh"

module host_requests (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        status_set,
	input  logic [`HPS_IO_STATUS_W-1:0] status_in,
	input  logic                        info_req,
	input  logic [7:0]                  info,
	input  hps_io_pkg::uio_cmd_e        cmd,
	input  logic                        frame_end,
	output hps_io_pkg::io_word_t        stflg_word,
	output hps_io_pkg::io_word_t        info_word,
	output logic [`HPS_IO_STATUS_W-1:0] status_req
);

	logic       old_status_set;
	logic       old_info_req;
	logic [3:0] stflg;
	logic [7:0] info_n;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_status_set <= 1'b0;
			old_info_req   <= 1'b0;
			stflg          <= '0;
			info_n         <= '0;
		end else begin
			old_status_set <= status_set;
			old_info_req   <= info_req;
			if (status_set && !old_status_set)
				stflg <= stflg + 4'd1;
			// host has read the info byte
			if (frame_end && cmd == hps_io_pkg::INFO)
				info_n <= '0;
			if (info_req && !old_info_req)
				info_n <= info;
		end
	end

	// status payload
	always_ff @(posedge clk_sys) begin
		if (status_set && !old_status_set)
			status_req <= status_in;
	end

	assign stflg_word = {8'h00, 4'hA, stflg};
	assign info_word  = {8'h00, info_n};

endmodule

// File: verilog/ps2_event_decode.sv
//////////////////////////////////////////////////
// ps2_event_decode
// keyboard and mouse frames to event words
// with toggle bits
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "hps_io_params.svh"

module ps2_event_decode (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  hps_io_pkg::uio_cmd_e          cmd,
	input  logic [`HPS_IO_WORD_CNT_W-1:0] word_idx,
	input  logic                          data_stb,
	input  hps_io_pkg::io_word_t          io_din,
	input  logic                          frame_end,
	output logic [10:0]                   ps2_key,
	output logic [24:0]                   ps2_mouse,
	output logic [15:0]                   ps2_mouse_ext
);

	logic        skip;
	logic        byte_ok;
	logic [31:0] key_raw;
	logic        pressed;
	logic        extended;
	logic [10:0] key_next;

	// high byte of all ones marks the frame as skipped
	assign byte_ok = ~&io_din[15:8] & ~skip;

	assign pressed  = (key_raw[15:8] != 8'hF0);
	assign extended = pressed ? (key_raw[15:8] == 8'hE0) : (key_raw[23:16] == 8'hE0);

	always_comb begin
		key_next = {~ps2_key[10], pressed, extended, key_raw[7:0]};
		case (key_raw)
			`HPS_IO_KEY_PRNSCR_DN: key_next[9:0] = `HPS_IO_CODE_PRNSCR_DN;
			`HPS_IO_KEY_PRNSCR_UP: key_next[9:0] = `HPS_IO_CODE_PRNSCR_UP;
			`HPS_IO_KEY_PAUSE_DN:  key_next[9:0] = `HPS_IO_CODE_PAUSE_DN;
			default: ;
		endcase
	end

	// raw key bytes, fresh from word 1
	always_ff @(posedge clk_sys) begin
		if (data_stb && cmd == hps_io_pkg::KBD && byte_ok)
			key_raw <= {(word_idx == 1) ? 24'h000000 : key_raw[23:0], io_din[7:0]};
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			skip          <= 1'b0;
			ps2_key       <= '0;
			ps2_mouse     <= '0;
			ps2_mouse_ext <= '0;
		end else if (frame_end) begin
			skip <= 1'b0;
			if (!skip && cmd == hps_io_pkg::KBD)
				ps2_key <= key_next;
			if (!skip && cmd == hps_io_pkg::MOUSE)
				ps2_mouse[24] <= ~ps2_mouse[24];
		end else if (data_stb) begin
			if (&io_din[15:8])
				skip <= 1'b1;
			if (cmd == hps_io_pkg::MOUSE && byte_ok) begin
				case (word_idx)
					1: begin
						ps2_mouse[7:0]     <= io_din[7:0];
						ps2_mouse_ext[7:0] <= {io_din[14], io_din[14:8]};
					end
					2: begin
						ps2_mouse[15:8]     <= io_din[7:0];
						ps2_mouse_ext[11:8] <= io_din[11:8];
					end
					3: begin
						ps2_mouse[23:16]     <= io_din[7:0];
						ps2_mouse_ext[15:12] <= io_din[11:8];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verilog/file_transfer.sv
//////////////////////////////////////////////////
// file_transfer
// file channel decoder, drives download address,
// byte data and write strobe
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "hps_io_params.svh"

module file_transfer (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      fp_enable,
	input  logic                      io_strobe,
	input  hps_io_pkg::io_word_t      io_din,
	output logic                      ioctl_download,
	output logic                      ioctl_wr,
	output logic [15:0]               ioctl_index,
	output logic [`HPS_IO_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                ioctl_dout,
	output logic [31:0]               ioctl_file_ext
);

	hps_io_pkg::fio_cmd_e      fcmd;
	logic                      has_cmd;
	logic [1:0]                cnt;
	logic                      wr;
	logic [`HPS_IO_ADDR_W-1:0] addr;

	//////////////////////////////////////////////////
	// command and control state
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			has_cmd        <= 1'b0;
			cnt            <= '0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
		end else begin
			// write pulse lags the data strobe by two cycles
			ioctl_wr <= wr;
			wr       <= 1'b0;
			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe && !has_cmd) begin
				fcmd    <= hps_io_pkg::fio_cmd_e'(io_din[7:0]);
				has_cmd <= 1'b1;
				cnt     <= '0;
			end else if (io_strobe) begin
				if (~&cnt)
					cnt <= cnt + 2'd1;
				case (fcmd)
					hps_io_pkg::FILE_INDEX: ioctl_index <= io_din;
					hps_io_pkg::FILE_INFO: begin
						if (cnt == 2'd0)
							ioctl_file_ext[31:16] <= io_din;
						else if (cnt == 2'd1)
							ioctl_file_ext[15:0] <= io_din;
					end
					hps_io_pkg::FILE_TX: begin
						if (cnt == 2'd0)
							ioctl_download <= (io_din[7:0] != 8'h00);
					end
					hps_io_pkg::FILE_TX_DAT: wr <= ioctl_download;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// address and data
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (fp_enable && io_strobe && has_cmd) begin
			if (fcmd == hps_io_pkg::FILE_TX) begin
				case (cnt)
					2'd0: if (io_din[7:0] != 8'h00) addr <= '0;
					2'd1: addr[15:0] <= io_din;
					2'd2: addr[`HPS_IO_ADDR_W-1:16] <= io_din[`HPS_IO_ADDR_W-17:0];
					default: ;
				endcase
			end else if (fcmd == hps_io_pkg::FILE_TX_DAT && ioctl_download) begin
				ioctl_addr <= addr;
				ioctl_dout <= io_din[7:0];
				addr       <= addr + 1'b1;
			end
		end
	end

endmodule

// File: verilog/hps_io.sv
//////////////////////////////////////////////////
// hps_io
// host command port for the game core: user
// commands, settings, requests, PS/2 events and
// the file download channel
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "hps_io_params.svh"

module hps_io (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         io_enable,
	input  logic                         fp_enable,
	input  logic                         io_strobe,
	input  hps_io_pkg::io_word_t         io_din,
	output hps_io_pkg::io_word_t         io_dout,
	input  hps_io_pkg::io_word_t         joy_raw,
	input  hps_io_pkg::io_word_t         status_menumask,
	output hps_io_pkg::joy_word_t        joystick_0,
	output hps_io_pkg::joy_word_t        joystick_1,
	output hps_io_pkg::joy_word_t        joystick_2,
	output hps_io_pkg::joy_word_t        joystick_3,
	output hps_io_pkg::joy_word_t        joystick_4,
	output hps_io_pkg::joy_word_t        joystick_5,
	output logic [1:0]                   buttons,
	output logic                         forced_scandoubler,
	output logic                         direct_video,
	output logic [`HPS_IO_STATUS_W-1:0]  status,
	input  logic [`HPS_IO_STATUS_W-1:0]  status_in,
	input  logic                         status_set,
	output logic [15:0]                  sdram_sz,
	input  logic                         info_req,
	input  logic [7:0]                   info,
	output logic [10:0]                  ps2_key,
	output logic [24:0]                  ps2_mouse,
	output logic [15:0]                  ps2_mouse_ext,
	output logic                         ioctl_download,
	output logic                         ioctl_wr,
	output logic [15:0]                  ioctl_index,
	output logic [`HPS_IO_ADDR_W-1:0]    ioctl_addr,
	output logic [7:0]                   ioctl_dout,
	output logic [31:0]                  ioctl_file_ext
);

	hps_io_pkg::uio_cmd_e               cmd;
	logic [`HPS_IO_WORD_CNT_W-1:0]      word_idx;
	logic                               data_stb;
	logic                               frame_end;
	hps_io_pkg::io_word_t               stflg_word;
	hps_io_pkg::io_word_t               info_word;
	logic [`HPS_IO_STATUS_W-1:0]        status_req;

	uio_frame u_frame (
		.clk_sys, .rst_n, .io_enable, .io_strobe, .io_din,
		.cmd, .word_idx, .data_stb, .frame_end,
		.stflg_word, .info_word, .status_req, .joy_raw, .status_menumask,
		.io_dout
	);

	uio_settings u_settings (
		.clk_sys, .rst_n, .cmd, .word_idx, .data_stb, .io_din,
		.joystick_0, .joystick_1, .joystick_2, .joystick_3, .joystick_4, .joystick_5,
		.buttons, .forced_scandoubler, .direct_video, .status, .sdram_sz
	);

	host_requests u_requests (
		.clk_sys, .rst_n, .status_set, .status_in, .info_req, .info,
		.cmd, .frame_end, .stflg_word, .info_word, .status_req
	);

	ps2_event_decode u_ps2 (
		.clk_sys, .rst_n, .cmd, .word_idx, .data_stb, .io_din, .frame_end,
		.ps2_key, .ps2_mouse, .ps2_mouse_ext
	);

	file_transfer u_file (
		.clk_sys, .rst_n, .fp_enable, .io_strobe, .io_din,
		.ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.ioctl_file_ext
	);

endmodule

// File: verification/hps_io_properties.sv
//////////////////////////////////////////////////
// hps_io_properties
// bus and download rules checked on the host port
//////////////////////////////////////////////////
`timescale 1ns/10ps

module hps_io_properties (
	input logic        clk_sys,
	input logic        rst_n,
	input logic        io_enable,
	input logic        fp_enable,
	input logic [15:0] io_dout,
	input logic        ioctl_wr,
	input logic        ioctl_download
);

	// failed assertion count
	int assert_fails = 0;

	wr_single_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |=> !ioctl_wr)
	else begin
		$error("ioctl_wr stayed high for more than one cycle");
		assert_fails++;
	end

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download)
	else begin
		$error("ioctl_wr pulsed outside a download");
		assert_fails++;
	end

	// io_dout clears one cycle after io_enable falls
	dout_idle_zero: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!io_enable && !$past(io_enable) && !fp_enable) |-> io_dout == 16'h0000)
	else begin
		$error("io_dout not zero outside a frame");
		assert_fails++;
	end

	enables_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(io_enable && fp_enable))
	else begin
		$error("io_enable and fp_enable high together");
		assert_fails++;
	end

endmodule

bind hps_io hps_io_properties u_props (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.io_enable      (io_enable),
	.fp_enable      (fp_enable),
	.io_dout        (io_dout),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download)
);

// File: verification/hps_io_tb.sv
//////////////////////////////////////////////////
// hps_io_tb
// table-driven testbench for the host command
// port, with a host bus model and write monitor
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "hps_io_params.svh"

module hps_io_tb;

	localparam int MAX_TESTS = 32;
	localparam int MAX_WORDS = 10;
	localparam int DL_BYTES  = 8;

	// core-side readback inputs
	localparam logic [15:0] JOY_RAW_VAL   = 16'h5AA5;
	localparam logic [15:0] MENU_MASK_VAL = 16'h0C30;

	// which output a table row compares
	localparam int SEL_NONE   = 0;
	localparam int SEL_CFG    = 1;
	localparam int SEL_JOY0   = 2;
	localparam int SEL_STATUS = 8;
	localparam int SEL_SDRAM  = 9;
	localparam int SEL_KEY    = 10;
	localparam int SEL_MOUSE  = 11;
	localparam int SEL_INDEX  = 12;
	localparam int SEL_DL     = 13;
	localparam int SEL_WRITES = 14;
	localparam int SEL_EXT    = 15;

	// core-side action before the frame
	localparam int PRE_NONE   = 0;
	localparam int PRE_STATUS = 1;
	localparam int PRE_INFO   = 2;

	logic                        clk_sys;
	logic                        rst_n;
	logic                        io_enable;
	logic                        fp_enable;
	logic                        io_strobe;
	logic [15:0]                 io_din;
	logic [15:0]                 io_dout;
	logic [15:0]                 joy_raw;
	logic [15:0]                 status_menumask;
	logic [31:0]                 joystick_0;
	logic [31:0]                 joystick_1;
	logic [31:0]                 joystick_2;
	logic [31:0]                 joystick_3;
	logic [31:0]                 joystick_4;
	logic [31:0]                 joystick_5;
	logic [1:0]                  buttons;
	logic                        forced_scandoubler;
	logic                        direct_video;
	logic [`HPS_IO_STATUS_W-1:0] status;
	logic [`HPS_IO_STATUS_W-1:0] status_in;
	logic                        status_set;
	logic [15:0]                 sdram_sz;
	logic                        info_req;
	logic [7:0]                  info;
	logic [10:0]                 ps2_key;
	logic [24:0]                 ps2_mouse;
	logic [15:0]                 ps2_mouse_ext;
	logic                        ioctl_download;
	logic                        ioctl_wr;
	logic [15:0]                 ioctl_index;
	logic [`HPS_IO_ADDR_W-1:0]   ioctl_addr;
	logic [7:0]                  ioctl_dout;
	logic [31:0]                 ioctl_file_ext;

	// frame table, word 0 in the low 16 bits
	string        t_name     [MAX_TESTS];
	logic         t_fp       [MAX_TESTS];
	int           t_len      [MAX_TESTS];
	logic [159:0] t_words    [MAX_TESTS];
	int           t_pre      [MAX_TESTS];
	int           t_sel      [MAX_TESTS];
	logic [127:0] t_exp      [MAX_TESTS];
	logic [159:0] t_rep      [MAX_TESTS];
	logic [9:0]   t_rep_mask [MAX_TESTS];

	int                        n_tests;
	int                        total_words;
	int                        errors;
	int                        tests_failed;
	int                        cycles;
	int                        cycle_limit;
	integer                    seed;
	logic [127:0]              st_first;
	logic [127:0]              st_last;
	logic [7:0]                info_val;
	logic [`HPS_IO_ADDR_W-1:0] wr_addr_q [$];
	logic [7:0]                wr_data_q [$];

	hps_io dut (
		.clk_sys(clk_sys), .rst_n(rst_n), .io_enable(io_enable), .fp_enable(fp_enable),
		.io_strobe(io_strobe), .io_din(io_din), .io_dout(io_dout), .joy_raw(joy_raw),
		.status_menumask(status_menumask), .joystick_0(joystick_0), .joystick_1(joystick_1),
		.joystick_2(joystick_2), .joystick_3(joystick_3), .joystick_4(joystick_4),
		.joystick_5(joystick_5), .buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.direct_video(direct_video), .status(status), .status_in(status_in),
		.status_set(status_set), .sdram_sz(sdram_sz), .info_req(info_req), .info(info),
		.ps2_key(ps2_key), .ps2_mouse(ps2_mouse), .ps2_mouse_ext(ps2_mouse_ext),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_file_ext(ioctl_file_ext)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	// download write monitor
	always @(negedge clk_sys) begin
		if (rst_n && ioctl_wr) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
	end

	task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic add_test(input string name, input logic fp, input int len,
			input logic [159:0] words, input int pre, input int sel, input logic [127:0] exp,
			input logic [159:0] rep, input logic [9:0] rep_mask);
		t_name[n_tests]     = name;
		t_fp[n_tests]       = fp;
		t_len[n_tests]      = len;
		t_words[n_tests]    = words;
		t_pre[n_tests]      = pre;
		t_sel[n_tests]      = sel;
		t_exp[n_tests]      = exp;
		t_rep[n_tests]      = rep;
		t_rep_mask[n_tests] = rep_mask;
		total_words += len;
		n_tests++;
	endtask

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////
	task automatic build_table();
		int           j;
		logic [15:0]  cfg_word;
		logic [15:0]  joy_cmd;
		logic [31:0]  joy_val;
		logic [127:0] st_data;
		logic [127:0] dl_words;
		logic         key_tgl;
		n_tests     = 0;
		total_words = 0;
		key_tgl     = 1'b0;

		// buttons 10 and direct video, scandoubler off
		cfg_word = 16'h04A2;
		add_test("cfg_a", 1'b0, 2, {cfg_word, 16'h0001}, PRE_NONE, SEL_CFG,
			{cfg_word[10], cfg_word[4], cfg_word[1:0]}, '0, '0);
		// buttons 01 and scandoubler, direct video off
		cfg_word = 16'h0011;
		add_test("cfg_b", 1'b0, 2, {cfg_word, 16'h0001}, PRE_NONE, SEL_CFG,
			{cfg_word[10], cfg_word[4], cfg_word[1:0]}, '0, '0);
		for (j = 0; j < `HPS_IO_NUM_JOY; j++) begin
			// JOY0 and JOY1, then JOY2 onwards from 0x10
			joy_cmd = 16'((j < 2) ? 2 + j : 14 + j);
			joy_val = $random(seed);
			add_test($sformatf("joy%0d", j), 1'b0, 3, {joy_val[31:16], joy_val[15:0], joy_cmd},
				PRE_NONE, SEL_JOY0 + j, joy_val, '0, '0);
		end
		st_data = {$random(seed), $random(seed), $random(seed), $random(seed)};
		add_test("status", 1'b0, 9, {st_data, 16'h001E}, PRE_NONE, SEL_STATUS, st_data, '0, '0);
		add_test("sdram_sz", 1'b0, 3, {16'h1111, 16'h8003, 16'h0031}, PRE_NONE, SEL_SDRAM,
			16'h8003, '0, '0);

		// two requests give flag word 0xA2
		st_first = {$random(seed), $random(seed), $random(seed), $random(seed)};
		st_last  = {$random(seed), $random(seed), $random(seed), $random(seed)};
		add_test("status_req", 1'b0, 9, {128'h0, 16'h0029}, PRE_STATUS, SEL_NONE, '0,
			{st_last, 16'h00A2}, 10'h1FF);
		info_val = 8'h5A;
		add_test("info", 1'b0, 1, 16'h0036, PRE_INFO, SEL_NONE, '0, {8'h00, info_val}, 10'h001);
		add_test("info_clear", 1'b0, 1, 16'h0036, PRE_NONE, SEL_NONE, '0, '0, 10'h001);

		// readbacks of the core inputs
		add_test("joy_raw", 1'b0, 2, {16'h0000, 16'h000F}, PRE_NONE, SEL_NONE, '0,
			{JOY_RAW_VAL, 16'h0000}, 10'h003);
		add_test("menumask", 1'b0, 3, {16'h0000, 16'h0000, 16'h002E}, PRE_NONE, SEL_NONE, '0,
			{16'h0000, MENU_MASK_VAL, 16'h0000}, 10'h007);

		// key event is toggle, pressed, extended, code
		key_tgl = ~key_tgl;
		add_test("key_press", 1'b0, 2, {16'h001C, 16'h0005}, PRE_NONE, SEL_KEY,
			{key_tgl, 1'b1, 1'b0, 8'h1C}, '0, '0);
		key_tgl = ~key_tgl;
		add_test("key_release", 1'b0, 3, {16'h001C, 16'h00F0, 16'h0005}, PRE_NONE, SEL_KEY,
			{key_tgl, 1'b0, 1'b0, 8'h1C}, '0, '0);
		key_tgl = ~key_tgl;
		add_test("key_ext", 1'b0, 3, {16'h0075, 16'h00E0, 16'h0005}, PRE_NONE, SEL_KEY,
			{key_tgl, 1'b1, 1'b1, 8'h75}, '0, '0);
		// full pause sequence E1 14 77 E1 F0 14 F0 77
		key_tgl = ~key_tgl;
		add_test("key_pause", 1'b0, 9, {16'h0077, 16'h00F0, 16'h0014, 16'h00F0, 16'h00E1,
			16'h0077, 16'h0014, 16'h00E1, 16'h0005}, PRE_NONE, SEL_KEY,
			{key_tgl, 10'h377}, '0, '0);
		// skipped frame keeps the last event
		add_test("key_skip", 1'b0, 3, {16'h001C, 16'hFF00, 16'h0005}, PRE_NONE, SEL_KEY,
			{key_tgl, 10'h377}, '0, '0);
		// high bytes carry the extension fields
		add_test("mouse", 1'b0, 4, {16'h0AFE, 16'h0312, 16'h0508, 16'h0004}, PRE_NONE,
			SEL_MOUSE, {16'hA305, 1'b1, 8'hFE, 8'h12, 8'h08}, '0, '0);

		// file download
		add_test("dl_info", 1'b1, 3, {16'h494E, 16'h2E42, 16'h0056}, PRE_NONE, SEL_EXT,
			32'h2E42494E, '0, '0);
		add_test("dl_index", 1'b1, 2, {16'h0003, 16'h0055}, PRE_NONE, SEL_INDEX,
			16'h0003, '0, '0);
		add_test("dl_start", 1'b1, 2, {16'h0001, 16'h0053}, PRE_NONE, SEL_DL, 1, '0, '0);
		dl_words = {$random(seed), $random(seed), $random(seed), $random(seed)};
		add_test("dl_data", 1'b1, 1 + DL_BYTES, {dl_words, 16'h0054}, PRE_NONE, SEL_WRITES,
			dl_words, '0, '0);
		add_test("dl_stop", 1'b1, 2, {16'h0000, 16'h0053}, PRE_NONE, SEL_DL, 0, '0, '0);
	endtask

	//////////////////////////////////////////////////
	// host and core side drivers
	//////////////////////////////////////////////////
	task automatic send_frame(input logic fp, input int len, input logic [159:0] words,
			output logic [159:0] replies);
		int i;
		replies = '0;
		@(posedge clk_sys);
		if (fp)
			fp_enable <= 1'b1;
		else
			io_enable <= 1'b1;
		for (i = 0; i < len; i++) begin
			@(posedge clk_sys);
			io_strobe <= 1'b1;
			io_din    <= words[i*16 +: 16];
			@(posedge clk_sys);
			io_strobe <= 1'b0;
			@(negedge clk_sys);
			replies[i*16 +: 16] = io_dout;
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		// frame end, then event update
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic pulse_status(input logic [127:0] value);
		@(posedge clk_sys);
		status_in  <= value;
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic pulse_info(input logic [7:0] value);
		@(posedge clk_sys);
		info     <= value;
		info_req <= 1'b1;
		@(posedge clk_sys);
		info_req <= 1'b0;
		@(posedge clk_sys);
	endtask

	function automatic logic [127:0] observed(input int sel);
		case (sel)
			SEL_CFG:      return {direct_video, forced_scandoubler, buttons};
			SEL_JOY0:     return joystick_0;
			SEL_JOY0 + 1: return joystick_1;
			SEL_JOY0 + 2: return joystick_2;
			SEL_JOY0 + 3: return joystick_3;
			SEL_JOY0 + 4: return joystick_4;
			SEL_JOY0 + 5: return joystick_5;
			SEL_STATUS:   return status;
			SEL_SDRAM:    return sdram_sz;
			SEL_KEY:      return ps2_key;
			SEL_MOUSE:    return {ps2_mouse_ext, ps2_mouse};
			SEL_INDEX:    return ioctl_index;
			SEL_DL:       return ioctl_download;
			SEL_EXT:      return ioctl_file_ext;
			default:      return '0;
		endcase
	endfunction

	// byte i lands at address i
	task automatic check_writes(input logic [127:0] data_words);
		int i;
		check(wr_addr_q.size(), DL_BYTES, "write pulse count");
		for (i = 0; i < wr_addr_q.size() && i < DL_BYTES; i++) begin
			check(wr_addr_q[i], i, $sformatf("write %0d address", i));
			check(wr_data_q[i], data_words[i*16 +: 8], $sformatf("write %0d data", i));
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s ok", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - err_before);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int           t;
		int           i;
		int           err_before;
		logic [159:0] replies;
		clk_sys         = 1'b0;
		rst_n           = 1'b0;
		io_enable       = 1'b0;
		fp_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		joy_raw         = JOY_RAW_VAL;
		status_menumask = MENU_MASK_VAL;
		status_in       = '0;
		status_set      = 1'b0;
		info_req        = 1'b0;
		info            = '0;
		errors          = 0;
		tests_failed    = 0;
		cycles          = 0;
		seed            = 32'h10be5a7d;
		build_table();
		// four cycles per word, margin for reset, gaps and requests
		cycle_limit = total_words * 4 + 20 * n_tests + 100;

		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		err_before = errors;
		check({joystick_5, joystick_4, joystick_3, joystick_2}, '0, "reset joystick 2-5");
		check({joystick_1, joystick_0, sdram_sz, buttons, forced_scandoubler, direct_video},
			'0, "reset joystick 0-1 and config");
		check(status, '0, "reset status");
		check({ps2_key, ps2_mouse, ps2_mouse_ext, ioctl_download, ioctl_wr, ioctl_index,
			ioctl_file_ext, io_dout}, '0, "reset events");
		report_test("reset", err_before);

		for (t = 0; t < n_tests; t++) begin
			err_before = errors;
			wr_addr_q.delete();
			wr_data_q.delete();
			case (t_pre[t])
				PRE_STATUS: begin
					pulse_status(st_first);
					pulse_status(st_last);
				end
				PRE_INFO: pulse_info(info_val);
				default: ;
			endcase
			send_frame(t_fp[t], t_len[t], t_words[t], replies);
			for (i = 0; i < MAX_WORDS; i++) begin
				if (t_rep_mask[t][i])
					check(replies[i*16 +: 16], t_rep[t][i*16 +: 16],
						$sformatf("%s reply %0d", t_name[t], i));
			end
			if (t_sel[t] == SEL_WRITES)
				check_writes(t_exp[t]);
			else if (t_sel[t] != SEL_NONE)
				check(observed(t_sel[t]), t_exp[t], t_name[t]);
			report_test(t_name[t], err_before);
		end

		@(negedge clk_sys);
		$display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
			n_tests + 1, tests_failed, errors, dut.u_props.assert_fails);
		if (errors == 0 && dut.u_props.assert_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: hps_io.f
+incdir+verilog
verilog/hps_io_pkg.sv
verilog/uio_frame.sv
verilog/uio_settings.sv
verilog/host_requests.sv
verilog/ps2_event_decode.sv
verilog/file_transfer.sv
verilog/hps_io.sv
verification/hps_io_properties.sv
verification/hps_io_tb.sv
